/* Bender.yml */
package:
  name: dbg_unit

sources:
  # rtl, package first.
  - files:
      - design/dbg_pkg.sv
      - design/dbg_scan.sv
      - design/dbg_imem_dump.sv
      - design/dbg_print.sv
      - design/dbg_imem.sv
      - design/dbg_unit.sv

  # testbench.
  - target: simulation
    files:
      - sim/tb_dbg_unit.sv

/* design/dbg_imem.sv */
`timescale 1ns/10ps
`default_nettype none

module dbg_imem (
    input  logic                        clk,
    input  logic                        we,
    input  logic [dbg_pkg::imem_aw-1:0] waddr,
    input  logic [31:0]                 wdata,
    input  logic [dbg_pkg::imem_aw-1:0] raddr,
    output logic [31:0]                 rdata
);
    import dbg_pkg::*;

    logic [31:0] mem [0:(1 << imem_aw) - 1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read is combinational for the sequencer.
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

/* design/dbg_imem_dump.sv */
`timescale 1ns/10ps
`default_nettype none

module dbg_imem_dump (
    input  logic                      clk,
    input  logic                      rstn,
    input  dbg_pkg::dbg_cmd_e         cmd,
    output logic                      req_rx,
    input  logic                      ack_rx,
    input  logic                      flag_rx,
    input  logic [31:0]               addr,
    output logic                      req_tx,
    output dbg_pkg::print_req_t       pr,
    input  logic                      ack_tx,
    output logic [dbg_pkg::imem_aw-1:0] rd_addr,
    input  logic [31:0]               rd_data,
    output logic                      done
);
    import dbg_pkg::*;

    typedef enum logic [3:0] {
        st_idle,
        st_scan,
        st_print_i,
        st_print_dash,
        st_print_addr,
        st_print_colon,
        st_print_word,
        st_print_cr,
        st_print_lf
    } dump_state_e;

    dump_state_e        state;
    logic [imem_aw-1:0] cur_addr;
    logic [imem_aw-1:0] next_addr;
    logic [3:0]         cnt;

    assign rd_addr = cur_addr;

    // item handed to the printer in each print state.
    always_comb begin
        pr.is_word = 1'b0;
        pr.data    = 32'h0;
        case (state)
            st_print_i:     pr.data = {24'h0, chr_i};
            st_print_dash:  pr.data = {24'h0, chr_dash};
            st_print_colon: pr.data = {24'h0, chr_colon};
            st_print_cr:    pr.data = {24'h0, chr_cr};
            st_print_lf:    pr.data = {24'h0, chr_lf};
            st_print_addr: begin
                pr.is_word = 1'b1;
                pr.data    = {{(32 - imem_aw){1'b0}}, cur_addr};
            end
            st_print_word: begin
                pr.is_word = 1'b1;
                pr.data    = rd_data;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= st_idle;
            req_rx    <= 1'b0;
            req_tx    <= 1'b0;
            cur_addr  <= '0;
            next_addr <= '0;
            cnt       <= 4'd0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (cmd != cmd_dump_i) begin
                state  <= st_idle;
                req_rx <= 1'b0;
                req_tx <= 1'b0;
                cnt    <= 4'd0;
            end else begin
                case (state)
                    st_idle: begin
                        // cmd still reads dump_i while done is high.
                        if (!done) begin
                            state  <= st_scan;
                            req_rx <= 1'b1;
                        end
                    end
                    st_scan: begin
                        if (ack_rx) begin
                            req_rx   <= 1'b0;
                            cur_addr <= flag_rx ? next_addr : addr[imem_aw-1:0];
                            state    <= st_print_i;
                        end
                    end
                    default: begin
                        if (ack_tx) begin
                            req_tx <= 1'b0;
                            case (state)
                                st_print_i:     state <= st_print_dash;
                                st_print_dash:  state <= st_print_addr;
                                st_print_addr:  state <= st_print_colon;
                                st_print_colon: state <= st_print_word;
                                st_print_word: begin
                                    cur_addr <= cur_addr + 1'b1;
                                    if (cnt == 4'(dump_words - 1)) begin
                                        cnt   <= 4'd0;
                                        state <= st_print_cr;
                                    end else begin
                                        cnt <= cnt + 4'd1;
                                    end
                                end
                                st_print_cr:    state <= st_print_lf;
                                default: begin
                                    next_addr <= cur_addr;
                                    done      <= 1'b1;
                                    state     <= st_idle;
                                end
                            endcase
                        end else begin
                            req_tx <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* design/dbg_pkg.sv */
`default_nettype none

package dbg_pkg;

    // command latched by the scanner.
    typedef enum logic [2:0] {
        cmd_none   = 3'd0,
        cmd_dump_i = 3'd1
    } dbg_cmd_e;

    // one item for the printer; a character uses data[7:0] only.
    typedef struct packed {
        logic        is_word;
        logic [31:0] data;
    } print_req_t;

    localparam int dump_words = 8;
    localparam int imem_aw    = 10;

    // ascii codes.
    localparam logic [7:0] chr_i     = 8'h49;
    localparam logic [7:0] chr_dash  = 8'h2d;
    localparam logic [7:0] chr_colon = 8'h3a;
    localparam logic [7:0] chr_cr    = 8'h0d;
    localparam logic [7:0] chr_lf    = 8'h0a;

endpackage

`default_nettype wire

/* design/dbg_print.sv */
`timescale 1ns/10ps
`default_nettype none

module dbg_print (
    input  logic                clk,
    input  logic                rstn,
    input  logic                req_tx,
    input  dbg_pkg::print_req_t pr,
    output logic                ack_tx,
    output logic [7:0]          tx_data,
    output logic                tx_valid,
    input  logic                tx_ready
);

    typedef enum logic {
        pr_idle,
        pr_send
    } print_state_e;

    print_state_e state;
    logic [2:0]   nib_cnt;
    logic         is_word;
    logic [31:0]  shreg;
    logic [3:0]   nib;
    logic         last;

    assign nib = shreg[31:28];

    // top nibble to ascii, upper case.
    always_comb begin
        if (!is_word) begin
            tx_data = shreg[7:0];
        end else if (nib < 4'd10) begin
            tx_data = {4'h0, nib} + 8'h30;
        end else begin
            tx_data = {4'h0, nib} + 8'h37;
        end
    end

    assign last     = !is_word || (nib_cnt == 3'd7);
    assign tx_valid = (state == pr_send) && tx_ready;
    assign ack_tx   = tx_valid && last;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= pr_idle;
            nib_cnt <= 3'd0;
        end else begin
            case (state)
                pr_idle: begin
                    if (req_tx) begin
                        state   <= pr_send;
                        nib_cnt <= 3'd0;
                    end
                end
                default: begin
                    if (tx_ready) begin
                        if (last) begin
                            state <= pr_idle;
                        end else begin
                            nib_cnt <= nib_cnt + 3'd1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == pr_idle && req_tx) begin
            is_word <= pr.is_word;
            shreg   <= pr.data;
        end else if (state == pr_send && tx_ready && is_word) begin
            shreg <= {shreg[27:0], 4'h0};
        end
    end

endmodule

`default_nettype wire

/* design/dbg_scan.sv */
`timescale 1ns/10ps
`default_nettype none

module dbg_scan (
    input  logic              clk,
    input  logic              rstn,
    input  logic [7:0]        rx_data,
    input  logic              rx_valid,
    input  logic              done,
    input  logic              req_rx,
    output dbg_pkg::dbg_cmd_e cmd,
    output logic              ack_rx,
    output logic              flag_rx,
    output logic [31:0]       addr
);
    import dbg_pkg::*;

    logic       collect;
    logic       cr_pend;
    logic [3:0] n_dig;
    logic       is_hex;
    logic [3:0] nib;
    logic       got_cr;

    // ascii hex digit decode, either case.
    always_comb begin
        is_hex = 1'b1;
        nib    = 4'h0;
        if (rx_data >= 8'h30 && rx_data <= 8'h39) begin
            nib = rx_data[3:0];
        end else if (rx_data >= 8'h41 && rx_data <= 8'h46) begin
            nib = rx_data[3:0] + 4'd9;
        end else if (rx_data >= 8'h61 && rx_data <= 8'h66) begin
            nib = rx_data[3:0] + 4'd9;
        end else begin
            is_hex = 1'b0;
        end
    end

    assign got_cr  = rx_valid && collect && (rx_data == chr_cr);
    assign flag_rx = (n_dig == 4'd0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cmd     <= cmd_none;
            collect <= 1'b0;
            cr_pend <= 1'b0;
            n_dig   <= 4'd0;
            ack_rx  <= 1'b0;
        end else if (done) begin
            cmd     <= cmd_none;
            collect <= 1'b0;
            cr_pend <= 1'b0;
            ack_rx  <= 1'b0;
        end else begin
            ack_rx <= 1'b0;
            if (cmd == cmd_none) begin
                if (rx_valid && rx_data == chr_i) begin
                    cmd     <= cmd_dump_i;
                    collect <= 1'b1;
                    n_dig   <= 4'd0;
                end
            end else if (collect) begin
                if (got_cr) begin
                    collect <= 1'b0;
                    // a CR ahead of the request waits for it.
                    if (req_rx) begin
                        ack_rx <= 1'b1;
                    end else begin
                        cr_pend <= 1'b1;
                    end
                end else if (rx_valid && is_hex && n_dig != 4'd8) begin
                    n_dig <= n_dig + 4'd1;
                end
            end else if (cr_pend && req_rx) begin
                ack_rx  <= 1'b1;
                cr_pend <= 1'b0;
            end
        end
    end

    // only the last eight digits survive the shift.
    always_ff @(posedge clk) begin
        if (cmd == cmd_none) begin
            addr <= 32'h0;
        end else if (collect && rx_valid && is_hex) begin
            addr <= {addr[27:0], nib};
        end
    end

endmodule

`default_nettype wire

/* design/dbg_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module dbg_unit (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic [7:0]                  rx_data,
    input  logic                        rx_valid,
    output logic [7:0]                  tx_data,
    output logic                        tx_valid,
    input  logic                        tx_ready,
    input  logic                        imem_we,
    input  logic [dbg_pkg::imem_aw-1:0] imem_waddr,
    input  logic [31:0]                 imem_wdata,
    output logic                        done
);
    import dbg_pkg::*;

    dbg_cmd_e           cmd;
    logic               req_rx;
    logic               ack_rx;
    logic               flag_rx;
    logic [31:0]        addr;
    logic               req_tx;
    print_req_t         pr;
    logic               ack_tx;
    logic [imem_aw-1:0] rd_addr;
    logic [31:0]        rd_data;

    dbg_scan dbg_scan_inst (
        .clk      (clk),
        .rstn     (rstn),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .done     (done),
        .req_rx   (req_rx),
        .cmd      (cmd),
        .ack_rx   (ack_rx),
        .flag_rx  (flag_rx),
        .addr     (addr)
    );

    dbg_imem_dump dbg_imem_dump_inst (
        .clk     (clk),
        .rstn    (rstn),
        .cmd     (cmd),
        .req_rx  (req_rx),
        .ack_rx  (ack_rx),
        .flag_rx (flag_rx),
        .addr    (addr),
        .req_tx  (req_tx),
        .pr      (pr),
        .ack_tx  (ack_tx),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .done    (done)
    );

    dbg_print dbg_print_inst (
        .clk      (clk),
        .rstn     (rstn),
        .req_tx   (req_tx),
        .pr       (pr),
        .ack_tx   (ack_tx),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    dbg_imem dbg_imem_inst (
        .clk   (clk),
        .we    (imem_we),
        .waddr (imem_waddr),
        .wdata (imem_wdata),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

endmodule

`default_nettype wire

/* sim/tb_dbg_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dbg_unit;
    import dbg_pkg::*;

    localparam int clk_period = 20;
    localparam int n_tests    = 6;
    localparam int mem_words  = 1 << imem_aw;

    logic               clk;
    logic               rstn;
    logic [7:0]         rx_data;
    logic               rx_valid;
    logic [7:0]         tx_data;
    logic               tx_valid;
    logic               tx_ready;
    logic               imem_we;
    logic [imem_aw-1:0] imem_waddr;
    logic [31:0]        imem_wdata;
    logic               done;

    logic               bp_en;
    logic [31:0]        shadow [0:mem_words-1];
    logic [7:0]         rx_q[$];
    logic [7:0]         exp_q[$];
    int                 done_cnt = 0;
    int                 error_cnt = 0;
    int                 check_cnt = 0;
    int                 test_cnt = 0;
    int                 fail_cnt = 0;
    int                 model_next = 0;

    dbg_unit dbg_unit_inst (
        .clk        (clk),
        .rstn       (rstn),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .imem_we    (imem_we),
        .imem_waddr (imem_waddr),
        .imem_wdata (imem_wdata),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // reply bytes and done pulses as the DUT issues them.
    always @(posedge clk) begin
        if (tx_valid && !tx_ready) begin
            error_cnt++;
            $display("tx_valid was issued while tx_ready was low");
        end
        if (tx_valid) begin
            rx_q.push_back(tx_data);
        end
        if (done) begin
            done_cnt++;
        end
    end

    // random back-pressure only while a test asks for it.
    always @(negedge clk) begin
        tx_ready <= bp_en ? 1'($urandom) : 1'b1;
    end

    initial begin
        #(n_tests * 200 * clk_period * 20);
        $display("timeout: the run did not reach its end in time");
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        check_cnt++;
        if (expected !== actual) begin
            error_cnt++;
            $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int e0);
        test_cnt++;
        if (error_cnt == e0) begin
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, error_cnt - e0);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rstn = 1'b0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;
    endtask

    task automatic load_memory();
        int a;
        for (a = 0; a < mem_words; a++) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_waddr = a[imem_aw-1:0];
            imem_wdata = $urandom;
            shadow[a]  = imem_wdata;
        end
        @(negedge clk);
        imem_we = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(negedge clk);
        rx_data  = b;
        rx_valid = 1'b1;
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    // the host ends every line with CR.
    task automatic send_line(input string text);
        int i;
        for (i = 0; i < text.len(); i++) begin
            send_byte(text[i]);
        end
        send_byte(chr_cr);
    endtask

    function automatic int hex_value(input logic [7:0] c);
        if (c >= 8'h30 && c <= 8'h39) return c - 8'h30;
        if (c >= 8'h41 && c <= 8'h46) return c - 8'h41 + 10;
        if (c >= 8'h61 && c <= 8'h66) return c - 8'h61 + 10;
        return -1;
    endfunction

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        if (n < 4'd10) return 8'h30 + n;
        return 8'h41 + n - 8'd10;
    endfunction

    // start address that the host line asks for.
    function automatic int model_start(input string text);
        int          i;
        int          v;
        int          n;
        logic [31:0] acc;
        acc = 32'h0;
        n   = 0;
        for (i = 1; i < text.len(); i++) begin
            v = hex_value(text[i]);
            if (v >= 0) begin
                acc = {acc[27:0], v[3:0]};
                n++;
            end
        end
        if (n == 0) return model_next;
        return acc % mem_words;
    endfunction

    task automatic push_hex(input logic [31:0] word);
        int k;
        for (k = 7; k >= 0; k--) begin
            exp_q.push_back(hex_char(word[4*k +: 4]));
        end
    endtask

    task automatic build_expected(input int start);
        int k;
        exp_q.delete();
        exp_q.push_back(chr_i);
        exp_q.push_back(chr_dash);
        push_hex(start);
        exp_q.push_back(chr_colon);
        for (k = 0; k < dump_words; k++) begin
            push_hex(shadow[(start + k) % mem_words]);
        end
        exp_q.push_back(chr_cr);
        exp_q.push_back(chr_lf);
    endtask

    task automatic wait_done(input string name, input int d0);
        int n;
        n = 0;
        while (done_cnt == d0 && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (done_cnt == d0) begin
            error_cnt++;
            $display("%s: the dump never signalled done within 2000 cycles", name);
        end
    endtask

    task automatic run_dump(input string name, input string text);
        int d0;
        int e0;
        int start;
        int i;
        d0    = done_cnt;
        start = model_start(text);
        build_expected(start);
        rx_q.delete();
        send_line(text);
        wait_done(name, d0);
        repeat (10) @(negedge clk);
        check({name, " done count"}, 1, done_cnt - d0);
        check({name, " byte count"}, exp_q.size(), rx_q.size());
        e0 = error_cnt;
        for (i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
            check(name, exp_q[i], rx_q[i]);
            if (error_cnt != e0) break;
        end
        model_next = (start + dump_words) % mem_words;
    endtask

    task automatic basic_dump();
        string hdr;
        int    e0;
        int    i;
        hdr = "I-000001A0:";
        e0  = error_cnt;
        run_dump("basic_dump", "I1A0");
        for (i = 0; i < hdr.len() && i < rx_q.size(); i++) begin
            check("basic_dump header", hdr[i], rx_q[i]);
        end
        report_test("basic_dump", e0);
    endtask

    task automatic continue_dump();
        int e0;
        e0 = error_cnt;
        run_dump("continue_dump", "I");
        report_test("continue_dump", e0);
    endtask

    task automatic backpressure_dump();
        logic [7:0] ref_q[$];
        int         e0;
        int         i;
        e0 = error_cnt;
        // this range wraps past the last memory word.
        run_dump("bp_plain", "I3FC");
        ref_q = rx_q;
        bp_en = 1'b1;
        run_dump("bp_random", "I3FC");
        bp_en = 1'b0;
        check("backpressure length", ref_q.size(), rx_q.size());
        for (i = 0; i < ref_q.size() && i < rx_q.size(); i++) begin
            check("backpressure bytes", ref_q[i], rx_q[i]);
        end
        report_test("backpressure_dump", e0);
    endtask

    task automatic filtered_address_dump();
        int e0;
        e0 = error_cnt;
        run_dump("filtered_address", "Iz0q1234g5678+9abC");
        report_test("filtered_address_dump", e0);
    endtask

    task automatic idle_bytes_ignored();
        int e0;
        int d0;
        e0 = error_cnt;
        d0 = done_cnt;
        rx_q.delete();
        send_line("x1A0-i?");
        repeat (40) @(negedge clk);
        check("idle tx bytes", 0, rx_q.size());
        check("idle done count", 0, done_cnt - d0);
        run_dump("idle_follow", "I");
        report_test("idle_bytes_ignored", e0);
    endtask

    task automatic omitted_after_reset();
        int e0;
        e0 = error_cnt;
        apply_reset();
        model_next = 0;
        run_dump("omitted_after_reset", "I");
        report_test("omitted_after_reset", e0);
    endtask

    initial begin
        rstn       = 1'b0;
        rx_data    = 8'h00;
        rx_valid   = 1'b0;
        tx_ready   = 1'b1;
        imem_we    = 1'b0;
        imem_waddr = '0;
        imem_wdata = 32'h0;
        bp_en      = 1'b0;
        void'($urandom(32'h17e5_63ae));
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        load_memory();
        basic_dump();
        continue_dump();
        backpressure_dump();
        filtered_address_dump();
        idle_bytes_ignored();
        omitted_after_reset();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, fail_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
design/dbg_pkg.sv
design/dbg_scan.sv
design/dbg_imem_dump.sv
design/dbg_print.sv
design/dbg_imem.sv
design/dbg_unit.sv
sim/tb_dbg_unit.sv
